/* build.f */
hw/rv_pkg.sv
hw/stage_if.sv
hw/regfile.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
verification/core_chk.sv
verification/core_tb.sv

/* Makefile */
SIM      := verilator
TOP      := core_tb
FILELIST := build.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verification/core_trace.txt */
// kind_rd_data: kind 1 sends data as an instruction word (rd byte unused),
// kind 2 expects the next writeback to hit rd with data
1_00_800000B7 // lui  x1, 0x80000
2_01_80000000
1_00_FFB00113 // addi x2, x0, -5
2_02_FFFFFFFB
1_00_000121B3 // slt  x3, x2, x0
2_03_00000001
1_00_0021B233 // sltu x4, x3, x2
2_04_00000001
1_00_4040D293 // srai x5, x1, 4
2_05_F8000000
1_00_40228333 // sub  x6, x5, x2
2_06_F8000005
1_00_00130013 // addi x0, x6, 1 (no writeback)
1_00_006003B3 // add  x7, x0, x6
2_07_F8000005
1_00_11223437 // lui  x8, 0x11223
2_08_11223000
1_00_34440413 // addi x8, x8, 0x344
2_08_11223344
1_00_00802823 // sw   x8, 16(x0)
1_00_FAA00493 // addi x9, x0, -86
2_09_FFFFFFAA
1_00_009008A3 // sb   x9, 17(x0)
1_00_109009A3 // sb   x9, 0x113(x0), wraps to byte 19
1_00_01002503 // lw   x10, 16(x0)
2_0A_AA22AA44
1_00_00701823 // sh   x7, 16(x0)
1_00_00400923 // sb   x4, 18(x0)
1_00_02802023 // sw   x8, 32(x0)
1_00_02901123 // sh   x9, 34(x0)
1_00_02300023 // sb   x3, 32(x0)
1_00_01002583 // lw   x11, 16(x0)
2_0B_AA010005
1_00_02002603 // lw   x12, 32(x0)
2_0C_FFAA3301
1_00_02300683 // lb   x13, 35(x0)
2_0D_FFFFFFFF
1_00_02204703 // lbu  x14, 34(x0)
2_0E_000000AA
1_00_02100783 // lb   x15, 33(x0)
2_0F_00000033
1_00_02004803 // lbu  x16, 32(x0)
2_10_00000001
1_00_02201883 // lh   x17, 34(x0)
2_11_FFFFFFAA
1_00_02205903 // lhu  x18, 34(x0)
2_12_0000FFAA
1_00_02001983 // lh   x19, 32(x0)
2_13_00003301
1_00_01005A03 // lhu  x20, 16(x0)
2_14_00000005
1_00_02002A83 // lw   x21, 32(x0)
2_15_FFAA3301
1_00_015A8B33 // add  x22, x21, x21
2_16_FF546602

/* verification/core_tb.sv */
`timescale 1ns/10ps

module core_tb
    import rv_pkg::*;
();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int dmem_words   = 64;
    localparam int trace_depth  = 128;
    // decode, execute, memory and writeback registers
    localparam int pipe_latency = 4;

    logic     clk;
    logic     reset;
    logic     in_valid;
    rv_word_t in_instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    rv_word_t wb_data;

    // kind nibble, rd byte, data word
    logic [43:0] trace_mem [trace_depth];
    rv_word_t    instr_q [$];
    reg_idx_t    exp_rd_q [$];
    rv_word_t    exp_data_q [$];
    int          n_instr = 0;
    int          n_checked = 0;
    int unsigned rng_state = 26666;

    core_top #(
        .dmem_words (dmem_words)
    ) i_core_top (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int unsigned xorshift32(input int unsigned x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: wb_rd is x%0d, expected x%0d", $time, got, exp);
            fail_run();
        end
    endtask

    task automatic check_data(input rv_word_t got, input rv_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: wb_data is %h, expected %h", $time, got, exp);
            fail_run();
        end
    endtask

    // kind 1 is an instruction, kind 2 an expected writeback
    task automatic load_trace();
        logic [43:0] entry;
        for (int i = 0; i < trace_depth; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("verification/core_trace.txt", trace_mem);
        for (int i = 0; i < trace_depth; i++) begin
            entry = trace_mem[i];
            if (entry[43:40] == 4'h1) begin
                instr_q.push_back(entry[31:0]);
            end else if (entry[43:40] == 4'h2) begin
                exp_rd_q.push_back(entry[36:32]);
                exp_data_q.push_back(entry[31:0]);
            end
        end
        if (instr_q.size() == 0) begin
            $display("trace file holds no instructions");
            fail_run();
        end else begin
            n_instr = instr_q.size();
        end
    endtask

    // outputs move on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("writeback to x%0d arrived with no expected entry left", wb_rd);
                fail_run();
            end else begin
                check_rd(wb_rd, exp_rd_q.pop_front());
                check_data(wb_data, exp_data_q.pop_front());
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (n_instr > 0);
        limit = reset_cycles + n_instr * 5 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the run did not reach its end", limit);
        fail_run();
    end

    initial begin
        int gap;
        in_valid = 1'b0;
        in_instr = '0;
        reset    = 1'b1;
        load_trace();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        foreach (instr_q[i]) begin
            in_valid = 1'b1;
            in_instr = instr_q[i];
            @(negedge clk);
            in_valid = 1'b0;
            in_instr = '0;
            // idle gap of 0 to 3 cycles
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state % 4);
            repeat (gap) @(negedge clk);
        end

        // let the last item leave the pipe
        repeat (pipe_latency + 2) @(posedge clk);
        if (exp_rd_q.size() != 0) begin
            $display("%0d expected writebacks never arrived", exp_rd_q.size());
            fail_run();
        end else begin
            $display("%0d writebacks checked", n_checked);
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* verification/core_chk.sv */
`timescale 1ns/10ps

module core_chk
    import rv_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     wb_valid,
    input reg_idx_t wb_rd,
    input logic     mem_valid,
    input logic     mem_read,
    input logic     mem_write
);

    // pipe holds nothing for four edges once reset drops
    quiet_after_reset: assert property (@(posedge clk)
        ($past(reset, 1) || $past(reset, 2) || $past(reset, 3) || $past(reset, 4))
        |-> !wb_valid)
        else $error("writeback strobe too soon after reset");

    rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_rd != '0)
        else $error("writeback strobe with rd of x0");

    // a load and a store never share one item
    mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_valid && mem_read && mem_write))
        else $error("memory read and write valid in the same cycle");

endmodule

bind execute_stage core_chk i_core_chk (
    .clk       (clk),
    .reset     (reset),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .mem_valid (ex_mem.valid),
    .mem_read  (ex_mem.ctrl.mem_read),
    .mem_write (ex_mem.ctrl.mem_write)
);

/* hw/core_top.sv */
`timescale 1ns/10ps

module core_top
    import rv_pkg::*;
#(
    parameter int dmem_words = 64
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  rv_word_t in_instr,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output rv_word_t wb_data
);

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    rv_word_t rs1_val;
    rv_word_t rs2_val;
    logic     mem_fwd_valid;
    reg_idx_t mem_fwd_rd;
    rv_word_t mem_fwd_data;

    stage_if id_ex ();
    stage_if ex_mem ();

    // writeback drives the write port directly
    regfile i_regfile (
        .clk      (clk),
        .reset    (reset),
        .rd_idx_a (rs1_idx),
        .rd_idx_b (rs2_idx),
        .wr_en    (wb_valid),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data),
        .rd_val_a (rs1_val),
        .rd_val_b (rs2_val)
    );

    decode_stage i_decode_stage (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .id_ex    (id_ex.src)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .reset         (reset),
        .id_ex         (id_ex.dst),
        .ex_mem        (ex_mem.src),
        .mem_fwd_valid (mem_fwd_valid),
        .mem_fwd_rd    (mem_fwd_rd),
        .mem_fwd_data  (mem_fwd_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    memory_stage #(
        .dmem_words (dmem_words)
    ) i_memory_stage (
        .clk           (clk),
        .reset         (reset),
        .ex_mem        (ex_mem.dst),
        .mem_fwd_valid (mem_fwd_valid),
        .mem_fwd_rd    (mem_fwd_rd),
        .mem_fwd_data  (mem_fwd_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/10ps

module memory_stage
    import rv_pkg::*;
#(
    parameter int dmem_words = 64
)
(
    input  logic     clk,
    input  logic     reset,
    stage_if.dst     ex_mem,
    output logic     mem_fwd_valid,
    output reg_idx_t mem_fwd_rd,
    output rv_word_t mem_fwd_data,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output rv_word_t wb_data
);

    localparam int addr_bits = $clog2(dmem_words);

    rv_word_t             ram [dmem_words];
    logic [addr_bits-1:0] word_idx;
    logic [1:0]           byte_off;
    logic [3:0]           byte_en;
    rv_word_t             st_data;
    rv_word_t             rd_word;
    rv_word_t             rd_shift;
    rv_word_t             ld_data;
    logic                 do_write;

    // address wraps modulo the RAM size
    assign word_idx = ex_mem.result[2 +: addr_bits];
    assign byte_off = ex_mem.result[1:0];

    always_comb begin
        case (ex_mem.ctrl.mem_size)
            mem_byte, mem_byte_u: byte_en = 4'b0001 << byte_off;
            mem_half, mem_half_u: byte_en = 4'b0011 << byte_off;
            default:              byte_en = 4'b1111;
        endcase
    end

    // move store data onto its byte lane
    assign st_data  = ex_mem.rs2_val << {byte_off, 3'b000};
    assign do_write = ex_mem.valid && ex_mem.ctrl.mem_write && !reset;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (do_write && byte_en[i]) begin
                ram[word_idx][8*i +: 8] <= st_data[8*i +: 8];
            end
        end
    end

    // combinational read, aligned down to lane 0
    assign rd_word  = ram[word_idx];
    assign rd_shift = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (ex_mem.ctrl.mem_size)
            mem_byte:   ld_data = {{(xlen-8){rd_shift[7]}}, rd_shift[7:0]};
            mem_byte_u: ld_data = {{(xlen-8){1'b0}}, rd_shift[7:0]};
            mem_half:   ld_data = {{(xlen-16){rd_shift[15]}}, rd_shift[15:0]};
            mem_half_u: ld_data = {{(xlen-16){1'b0}}, rd_shift[15:0]};
            default:    ld_data = rd_word;
        endcase
    end

    assign mem_fwd_valid = ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd != '0;
    assign mem_fwd_rd    = ex_mem.rd;
    assign mem_fwd_data  = (ex_mem.ctrl.wb_sel == wb_mem) ? ld_data : ex_mem.result;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_fwd_valid;
        end
        wb_rd   <= mem_fwd_rd;
        wb_data <= mem_fwd_data;
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    stage_if.dst     id_ex,
    stage_if.src     ex_mem,
    input  logic     mem_fwd_valid,
    input  reg_idx_t mem_fwd_rd,
    input  rv_word_t mem_fwd_data,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  rv_word_t wb_data
);

    rv_word_t opnd_a;
    rv_word_t rs2_fwd;
    rv_word_t opnd_b;
    rv_word_t alu_res;

    // youngest producer wins, x0 is hardwired
    function automatic rv_word_t fwd_val(input reg_idx_t idx, input rv_word_t reg_val);
        if (idx == '0) begin
            return '0;
        end else if (mem_fwd_valid && mem_fwd_rd == idx) begin
            return mem_fwd_data;
        end else if (wb_valid && wb_rd == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign opnd_a  = fwd_val(id_ex.rs1, id_ex.rs1_val);
    assign rs2_fwd = fwd_val(id_ex.rs2, id_ex.rs2_val);
    assign opnd_b  = id_ex.ctrl.b_is_imm ? id_ex.result : rs2_fwd;

    // loads and stores use add for the byte address
    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:    alu_res = opnd_a + opnd_b;
            alu_sub:    alu_res = opnd_a - opnd_b;
            alu_sll:    alu_res = opnd_a << opnd_b[4:0];
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
            alu_sltu:   alu_res = {{(xlen-1){1'b0}}, opnd_a < opnd_b};
            alu_xor:    alu_res = opnd_a ^ opnd_b;
            alu_srl:    alu_res = opnd_a >> opnd_b[4:0];
            alu_sra:    alu_res = $signed(opnd_a) >>> opnd_b[4:0];
            alu_or:     alu_res = opnd_a | opnd_b;
            alu_and:    alu_res = opnd_a & opnd_b;
            alu_pass_b: alu_res = opnd_b;
            default:    alu_res = opnd_a + opnd_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
        ex_mem.ctrl    <= id_ex.ctrl;
        ex_mem.rd      <= id_ex.rd;
        ex_mem.result  <= alu_res;
        ex_mem.rs1_val <= opnd_a;
        // store data, already forwarded
        ex_mem.rs2_val <= rs2_fwd;
        ex_mem.rs1     <= id_ex.rs1;
        ex_mem.rs2     <= id_ex.rs2;
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  rv_word_t in_instr,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  rv_word_t rs1_val,
    input  rv_word_t rs2_val,
    stage_if.src     id_ex
);

    logic     ir_valid;
    instr_u   ir;
    ctrl_t    ctrl;
    rv_word_t imm;
    rv_word_t i_imm;
    rv_word_t s_imm;
    rv_word_t u_imm;

    // alt picks sub and sra over add and srl
    function automatic alu_op_t alu_func(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // instruction register
    always_ff @(posedge clk) begin
        if (reset) begin
            ir_valid <= 1'b0;
        end else begin
            ir_valid <= in_valid;
        end
        ir <= in_instr;
    end

    assign rs1_idx = ir.r.rs1;
    assign rs2_idx = ir.r.rs2;

    assign i_imm = {{(xlen-12){ir.si.imm_hi[6]}}, ir.si.imm_hi, ir.si.rs2_imm_lo};
    assign s_imm = {{(xlen-12){ir.si.imm_hi[6]}}, ir.si.imm_hi, ir.si.imm_lo};
    assign u_imm = {ir.si.imm_hi, ir.si.rs2_imm_lo, ir.si.rs1, ir.si.funct3, 12'b0};

    always_comb begin
        ctrl = '{alu_op: alu_add, b_is_imm: 1'b0, mem_read: 1'b0, mem_write: 1'b0,
                 mem_size: mem_word, wb_sel: wb_alu, reg_write: 1'b0};
        imm  = i_imm;
        case (opcode_t'(ir.r.opcode))
            op_reg: begin
                ctrl.alu_op    = alu_func(ir.r.funct3, ir.r.funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                // srai is the only immediate op with an alternate form
                ctrl.alu_op    = alu_func(ir.r.funct3, ir.r.funct7[5] && ir.r.funct3 == 3'b101);
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = u_imm;
            end
            op_load: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.mem_size  = mem_size_t'(ir.r.funct3);
                ctrl.wb_sel    = wb_mem;
                ctrl.reg_write = 1'b1;
            end
            op_store: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = mem_size_t'(ir.r.funct3);
                imm            = s_imm;
            end
            default: begin
                // unknown opcode leaves no architectural trace
            end
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= ir_valid;
        end
        id_ex.ctrl    <= ctrl;
        id_ex.rd      <= ir.r.rd;
        id_ex.result  <= imm;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.rs1     <= ir.r.rs1;
        id_ex.rs2     <= ir.r.rs2;
    end

endmodule

/* hw/regfile.sv */
`timescale 1ns/10ps

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  rv_word_t wr_data,
    output rv_word_t rd_val_a,
    output rv_word_t rd_val_b
);

    rv_word_t regs [32];

    always_ff @(posedge clk) begin
        if (!reset && wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-first, so decode sees a value retiring this cycle
    always_comb begin
        rd_val_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
        rd_val_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];
        if (rd_idx_a == '0) begin
            rd_val_a = '0;
        end
        if (rd_idx_b == '0) begin
            rd_val_b = '0;
        end
    end

endmodule

/* hw/stage_if.sv */
`timescale 1ns/10ps

interface stage_if
    import rv_pkg::*;
();

    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rd;
    // immediate between decode and execute, ALU result after execute
    rv_word_t result;
    rv_word_t rs1_val;
    rv_word_t rs2_val;
    reg_idx_t rs1;
    reg_idx_t rs2;

    modport src (
        output valid, ctrl, rd, result, rs1_val, rs2_val, rs1, rs2
    );

    modport dst (
        input valid, ctrl, rd, result, rs1_val, rs2_val, rs1, rs2
    );

endinterface

/* hw/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] rv_word_t;
    typedef logic [4:0]      reg_idx_t;

    // only the opcodes this core executes
    typedef enum logic [6:0] {
        op_illegal = 7'b0000000,
        op_load    = 7'b0000011,
        op_imm     = 7'b0010011,
        op_store   = 7'b0100011,
        op_reg     = 7'b0110011,
        op_lui     = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // encoded as funct3 of the load/store
    typedef enum logic [2:0] {
        mem_byte   = 3'b000,
        mem_half   = 3'b001,
        mem_word   = 3'b010,
        mem_byte_u = 3'b100,
        mem_half_u = 3'b101
    } mem_size_t;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      b_is_imm;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        wb_sel_t   wb_sel;
        logic      reg_write;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I and S formats share the upper immediate bits
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2_imm_lo;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } si_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        si_fmt_t si;
    } instr_u;

endpackage
